//--- cpu_top.f
+incdir+.
cpu_isa_pkg.sv
cpu_bus_pkg.sv
cpu_fetch.sv
cpu_regfile.sv
cpu_alu.sv
cpu_io_master.sv
cpu_control.sv
cpu_top.sv
tb_cpu.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_cpu
FILELIST   ?= cpu_top.f
OBJDIR     ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tb_cpu.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu;

  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int PROG_DEPTH = 1 << `CPU_PC_W;
  localparam int MEM_AW     = 6;
  localparam int MEM_WORDS  = 1 << MEM_AW;
  localparam int MAX_WAIT   = 4;
  localparam int NUM_TESTS  = 5;
  localparam int MAX_STEPS  = 4096;
  localparam logic [31:0] SEED = 32'h4946_d87a;

  logic                   clk;
  logic                   reset;
  logic [`CPU_DATA_W-1:0] instr_word;
  logic [`CPU_PC_W-1:0]   iaddr;
  wb_rsp_t                wb_rsp = '0;
  wb_req_t                wb_req;
  logic                   halted;

  // program rom and slave data memory
  logic [`CPU_DATA_W-1:0] prog [0:PROG_DEPTH-1];
  logic [`CPU_DATA_W-1:0] mem  [0:MEM_WORDS-1];
  int                     prog_len;

  // stores predicted by the model, stores seen by the slave
  wb_req_t exp_q[$];
  wb_req_t obs_q[$];
  int      obs_idx = 0;

  int     errors;
  int     checks;
  int     wait_left   = 0;
  logic   slave_busy  = 1'b0;
  logic   limit_ready = 1'b0;
  longint limit_ns;

  cpu_top dut (
    .clk        (clk),
    .reset      (reset),
    .instr_word (instr_word),
    .iaddr      (iaddr),
    .wb_rsp     (wb_rsp),
    .wb_req     (wb_req),
    .halted     (halted)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // instruction port answers in the same cycle
  assign instr_word = prog[iaddr];

  // fill pattern, every address bit changes the word
  function automatic logic [`CPU_DATA_W-1:0] mem_init(input int idx);
    logic [`CPU_DATA_W-1:0] a;
    a = 16'(idx);
    return 16'h3c5a ^ (a * 16'h0b0d);
  endfunction

  // wishbone slave, ack after 0 to 4 idle cycles
  always @(negedge clk)
  begin
    if (reset)
    begin
      wb_rsp     <= '0;
      slave_busy = 1'b0;
      obs_q.delete();
      for (int i = 0; i < MEM_WORDS; i++)
        mem[i] = mem_init(i);
    end
    else if (wb_rsp.ack)
      // master dropped cyc on the ack edge
      wb_rsp.ack <= 1'b0;
    else if (wb_req.cyc && wb_req.stb)
    begin
      if (!slave_busy)
      begin
        slave_busy = 1'b1;
        wait_left  = int'($urandom % (MAX_WAIT + 1));
      end
      if (wait_left == 0)
      begin
        slave_busy = 1'b0;
        wb_rsp.ack <= 1'b1;
        if (wb_req.we)
        begin
          mem[wb_req.adr[MEM_AW-1:0]] = wb_req.dat;
          obs_q.push_back(wb_req);
        end
        else
          wb_rsp.dat <= mem[wb_req.adr[MEM_AW-1:0]];
      end
      else
        wait_left--;
    end
  end

  // instruction word builders
  function automatic logic [15:0] enc_op(input opcode_e op, input int rd, input int ra,
                                         input int rb);
    return {op, 4'(rd), 4'(ra), 4'(rb)};
  endfunction

  function automatic logic [15:0] enc_ldi(input int rd, input int imm);
    return {LDI, 4'(rd), 8'(imm)};
  endfunction

  function automatic logic [15:0] enc_jump(input opcode_e op, input int target);
    return {op, {(12 - `CPU_PC_W){1'b0}}, `CPU_PC_W'(target)};
  endfunction

  task automatic put(input logic [15:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  function automatic string test_name(input int id);
    case (id)
      0: return "alu ops";
      1: return "register zero";
      2: return "branches";
      3: return "loads with wait states";
      default: return "reset and halt";
    endcase
  endfunction

  task automatic load_program(input int id);
    // empty rom reads as nop
    for (int i = 0; i < PROG_DEPTH; i++)
      prog[i] = '0;
    prog_len = 0;
    case (id)
      0:
      begin
        put(enc_ldi(1, 8'h7f));
        put(enc_ldi(2, -1));
        put(enc_ldi(3, 8'h20));
        // 0x7f + 0xffff wraps
        put(enc_op(ADD, 4, 1, 2));
        put(enc_op(ST, 0, 4, 3));
        put(enc_ldi(5, 8'h21));
        put(enc_op(SUB, 6, 1, 2));
        put(enc_op(ST, 0, 6, 5));
        put(enc_ldi(5, 8'h22));
        put(enc_op(AND, 7, 1, 2));
        put(enc_op(ST, 0, 7, 5));
        put(enc_ldi(5, 8'h23));
        put(enc_op(OR, 8, 1, 2));
        put(enc_op(ST, 0, 8, 5));
        put(enc_ldi(5, 8'h24));
        put(enc_op(XOR, 9, 1, 2));
        put(enc_op(ST, 0, 9, 5));
        // negative immediate doubled
        put(enc_ldi(10, 8'h80));
        put(enc_op(ADD, 11, 10, 10));
        put(enc_ldi(5, 8'h25));
        put(enc_op(ST, 0, 11, 5));
        put(enc_op(HALT, 0, 0, 0));
      end
      1:
      begin
        put(enc_ldi(0, 8'h55));
        put(enc_ldi(1, 8'h30));
        put(enc_op(ST, 0, 0, 1));
        put(enc_op(ADD, 0, 1, 1));
        put(enc_ldi(2, 8'h31));
        put(enc_op(ST, 0, 0, 2));
        put(enc_op(ADD, 3, 0, 1));
        put(enc_op(ST, 0, 3, 2));
        // r0 as address
        put(enc_op(ST, 0, 1, 0));
        put(enc_op(HALT, 0, 0, 0));
      end
      2:
      begin
        put(enc_ldi(1, 5));
        put(enc_ldi(2, 5));
        put(enc_ldi(3, 8'h10));
        // 3: zero result sets the flag, 4: ldi keeps it
        put(enc_op(SUB, 4, 1, 2));
        put(enc_ldi(5, 7));
        // 5: taken
        put(enc_jump(JZ, 8));
        put(enc_op(ST, 0, 5, 3));
        put(enc_op(HALT, 0, 0, 0));
        // 8
        put(enc_op(ST, 0, 1, 3));
        // 9: not taken
        put(enc_jump(JNZ, 6));
        put(enc_ldi(3, 8'h11));
        put(enc_op(ST, 0, 2, 3));
        // 12: nonzero result clears the flag, 13: zero immediate keeps it clear
        put(enc_op(ADD, 4, 1, 2));
        put(enc_ldi(6, 0));
        // 14: not taken, 15: taken
        put(enc_jump(JZ, 6));
        put(enc_jump(JNZ, 18));
        put(enc_op(ST, 0, 6, 3));
        put(enc_op(HALT, 0, 0, 0));
        // 18
        put(enc_op(ST, 0, 4, 3));
        put(enc_jump(JMP, 21));
        put(enc_op(ST, 0, 4, 0));
        // 21
        put(enc_op(HALT, 0, 0, 0));
      end
      3:
      begin
        put(enc_ldi(1, 5));
        put(enc_ldi(2, 6));
        put(enc_op(LD, 3, 0, 1));
        put(enc_op(LD, 4, 0, 2));
        put(enc_ldi(5, 8'h38));
        put(enc_op(ST, 0, 3, 5));
        put(enc_ldi(6, 8'h39));
        put(enc_op(ST, 0, 4, 6));
        put(enc_op(ADD, 9, 3, 4));
        put(enc_ldi(8, 8'h3a));
        put(enc_op(ST, 0, 9, 8));
        // read back what was just stored
        put(enc_op(LD, 10, 0, 8));
        put(enc_ldi(11, 8'h3b));
        put(enc_op(ST, 0, 10, 11));
        put(enc_op(LD, 12, 0, 5));
        put(enc_op(ADD, 13, 12, 9));
        put(enc_op(ST, 0, 13, 11));
        put(enc_op(HALT, 0, 0, 0));
      end
      default:
      begin
        put(enc_ldi(1, 8'h12));
        put(enc_ldi(2, 8'h3f));
        put(enc_op(ST, 0, 1, 2));
        put(enc_op(HALT, 0, 0, 0));
        // never reached
        put(enc_op(ST, 0, 2, 2));
      end
    endcase
  endtask

  // instruction level model of the rom program
  // fills exp_q, returns the executed instruction count
  function automatic int run_model();
    logic [`CPU_DATA_W-1:0] r [0:15];
    logic [`CPU_DATA_W-1:0] m [0:MEM_WORDS-1];
    logic [`CPU_PC_W-1:0]   pc;
    logic [`CPU_DATA_W-1:0] w;
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] b;
    logic [`CPU_DATA_W-1:0] res;
    logic [3:0]             rd;
    logic                   flag;
    logic                   alu_hit;
    logic                   done;
    opcode_e                op;
    wb_req_t                st;
    int                     count;
    exp_q.delete();
    for (int i = 0; i < 16; i++)
      r[i] = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      m[i] = mem_init(i);
    pc    = '0;
    flag  = 1'b0;
    done  = 1'b0;
    count = 0;
    while (!done && count < MAX_STEPS)
    begin
      w     = prog[pc];
      pc    = pc + 1'b1;
      count++;
      op    = opcode_e'(w[15:12]);
      rd    = w[11:8];
      a     = r[w[7:4]];
      b     = r[w[3:0]];
      res   = '0;
      alu_hit = 1'b1;
      case (op)
        ADD: res = a + b;
        SUB: res = a - b;
        AND: res = a & b;
        OR: res = a | b;
        XOR: res = a ^ b;
        default: alu_hit = 1'b0;
      endcase
      if (alu_hit)
      begin
        if (rd != 0)
          r[rd] = res;
        flag = (res == '0);
      end
      case (op)
        LDI:
          if (rd != 0)
            r[rd] = {{8{w[7]}}, w[7:0]};
        JMP:
          pc = w[`CPU_PC_W-1:0];
        JZ:
          if (flag)
            pc = w[`CPU_PC_W-1:0];
        JNZ:
          if (!flag)
            pc = w[`CPU_PC_W-1:0];
        LD:
          if (rd != 0)
            r[rd] = m[b[MEM_AW-1:0]];
        ST:
        begin
          m[b[MEM_AW-1:0]] = a;
          st = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: b, dat: a};
          exp_q.push_back(st);
        end
        HALT:
          done = 1'b1;
        default:
          done = done;
      endcase
    end
    return count;
  endfunction

  task automatic check_store(input wb_req_t got, input wb_req_t exp);
    checks++;
    if (got.adr !== exp.adr)
    begin
      errors++;
      $display("** Error: wb_req.adr got 0x%h expected 0x%h", got.adr, exp.adr);
    end
    if (got.dat !== exp.dat)
    begin
      errors++;
      $display("** Error: wb_req.dat got 0x%h expected 0x%h at adr 0x%h",
               got.dat, exp.dat, exp.adr);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_iaddr(input logic [`CPU_PC_W-1:0] got,
                             input logic [`CPU_PC_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: iaddr got 0x%h expected 0x%h", got, exp);
    end
  endtask

  // halted must rise within the cycle budget of the program
  task automatic check_halt(input int limit_cycles);
    int n;
    n = 0;
    while (!halted && n < limit_cycles)
    begin
      @(negedge clk);
      n++;
    end
    checks++;
    if (!halted)
    begin
      errors++;
      $display("halted did not rise within %0d cycles", limit_cycles);
    end
  endtask

  // each store the slave took is compared against the next predicted one
  always @(posedge clk)
  begin
    if (reset)
      obs_idx = 0;
    else if (obs_idx < obs_q.size())
    begin
      if (halted)
      begin
        errors++;
        $display("store to adr 0x%h happened after halt", obs_q[obs_idx].adr);
      end
      else if (obs_idx >= exp_q.size())
      begin
        errors++;
        $display("extra store to adr 0x%h that the model does not predict",
                 obs_q[obs_idx].adr);
      end
      else
        check_store(obs_q[obs_idx], exp_q[obs_idx]);
      obs_idx++;
    end
  end

  task automatic run_test(input int id);
    int count;
    int errors_before;
    errors_before = errors;
    load_program(id);
    count = run_model();
    @(negedge clk);
    reset = 1'b1;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    // outputs straight after reset
    check_bit(wb_req.cyc, 1'b0, "wb_req.cyc");
    check_bit(wb_req.stb, 1'b0, "wb_req.stb");
    check_bit(halted, 1'b0, "halted");
    check_iaddr(iaddr, '0);
    check_halt(count * (3 + MAX_WAIT) + 20);
    // quiet cycles, a late store shows up here
    repeat (8) @(negedge clk);
    check_bit(halted, 1'b1, "halted");
    if (obs_q.size() < exp_q.size())
    begin
      errors++;
      $display("only %0d of %0d expected stores appeared", obs_q.size(), exp_q.size());
    end
    $display("test %0d %s: %0d instructions, %0d stores, %s", id, test_name(id), count,
             exp_q.size(), (errors == errors_before) ? "passed" : "failed");
  endtask

  initial
  begin
    int total_cycles;
    int count;
    void'($urandom(SEED));
    reset  = 1'b1;
    errors = 0;
    checks = 0;
    total_cycles = 0;
    // time budget from the model's instruction counts
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      load_program(t);
      count = run_model();
      total_cycles += count * (3 + MAX_WAIT) + 20;
    end
    limit_ns    = longint'(total_cycles) * CLK_PERIOD;
    limit_ready = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++)
      run_test(t);
    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    wait (limit_ready);
    #(limit_ns);
    $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- cpu_top.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_top
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`CPU_DATA_W-1:0] instr_word,
  output logic [`CPU_PC_W-1:0]   iaddr,
  input  cpu_bus_pkg::wb_rsp_t   wb_rsp,
  output cpu_bus_pkg::wb_req_t   wb_req,
  output logic                   halted
);

  import cpu_isa_pkg::*;

  ctrl_t                  ctrl;
  instr_t                 instr;
  logic                   zero;
  logic                   bus_done;
  logic [`CPU_DATA_W-1:0] rd1;
  logic [`CPU_DATA_W-1:0] rd2;
  logic [`CPU_DATA_W-1:0] alu_y;
  logic [`CPU_DATA_W-1:0] rdata;

  // decoder and state machine
  cpu_control u_control (
    .clk      (clk),
    .reset    (reset),
    .instr    (instr),
    .zero     (zero),
    .bus_done (bus_done),
    .ctrl     (ctrl),
    .halted   (halted)
  );

  // pc and instruction register
  cpu_fetch u_fetch (
    .clk         (clk),
    .reset       (reset),
    .fetch_en    (ctrl.fetch_en),
    .branch_take (ctrl.branch_take),
    .instr_word  (instr_word),
    .iaddr       (iaddr),
    .instr       (instr)
  );

  cpu_regfile u_regfile (
    .clk   (clk),
    .reset (reset),
    .instr (instr),
    .ctrl  (ctrl),
    .alu_y (alu_y),
    .rdata (rdata),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  cpu_alu u_alu (
    .clk   (clk),
    .reset (reset),
    .instr (instr),
    .ctrl  (ctrl),
    .a     (rd1),
    .b     (rd2),
    .y     (alu_y),
    .zero  (zero)
  );

  // rb holds the address, ra the store data
  cpu_io_master u_io_master (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .adr      (rd2),
    .wdata    (rd1),
    .wb_rsp   (wb_rsp),
    .wb_req   (wb_req),
    .rdata    (rdata),
    .bus_done (bus_done)
  );

endmodule

//--- cpu_control.sv
`timescale 1ns/10ps

module cpu_control
(
  input  logic                clk,
  input  logic                reset,
  input  cpu_isa_pkg::instr_t instr,
  input  logic                zero,
  input  logic                bus_done,
  output cpu_isa_pkg::ctrl_t  ctrl,
  output logic                halted
);

  import cpu_isa_pkg::*;

  typedef enum logic [1:0] {
    FETCH   = 2'd0,
    EXECUTE = 2'd1,
    BUS     = 2'd2,
    HALTED  = 2'd3
  } state_e;

  state_e  state;
  state_e  state_nxt;
  alu_op_e alu_sel;

  // opcode to alu operation, only used when an enable is set
  always_comb
  begin
    case (instr.opcode)
      SUB:
        alu_sel = ALU_SUB;
      AND:
        alu_sel = ALU_AND;
      OR:
        alu_sel = ALU_OR;
      XOR:
        alu_sel = ALU_XOR;
      LDI:
        alu_sel = ALU_IMM;
      default:
        alu_sel = ALU_ADD;
    endcase
  end

  // decoder and next state
  always_comb
  begin
    ctrl.reg_we      = 1'b0;
    ctrl.wb_src      = SRC_ALU;
    ctrl.alu_op      = alu_sel;
    ctrl.flag_load   = 1'b0;
    ctrl.fetch_en    = 1'b0;
    ctrl.branch_take = 1'b0;
    ctrl.bus_start   = 1'b0;
    ctrl.bus_we      = 1'b0;
    state_nxt        = state;

    case (state)
      FETCH:
      begin
        // instruction register loads and pc increments
        ctrl.fetch_en = 1'b1;
        state_nxt     = EXECUTE;
      end
      EXECUTE:
      begin
        state_nxt = FETCH;
        case (instr.opcode)
          ADD, SUB, AND, OR, XOR:
          begin
            ctrl.reg_we    = 1'b1;
            ctrl.flag_load = 1'b1;
          end
          // immediate load, flag untouched
          LDI:
            ctrl.reg_we = 1'b1;
          JMP:
            ctrl.branch_take = 1'b1;
          JZ:
            ctrl.branch_take = zero;
          JNZ:
            ctrl.branch_take = !zero;
          LD:
          begin
            ctrl.bus_start = 1'b1;
            state_nxt      = BUS;
          end
          ST:
          begin
            ctrl.bus_start = 1'b1;
            ctrl.bus_we    = 1'b1;
            state_nxt      = BUS;
          end
          HALT:
            state_nxt = HALTED;
          // nop and unused codes
          default:
            state_nxt = FETCH;
        endcase
      end
      BUS:
      begin
        // stall until the master reports completion
        if (bus_done)
        begin
          state_nxt = FETCH;
          if (instr.opcode == LD)
          begin
            ctrl.reg_we = 1'b1;
            ctrl.wb_src = SRC_BUS;
          end
        end
      end
      // halted is terminal until reset
      default:
        state_nxt = HALTED;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state <= FETCH;
    else
      state <= state_nxt;
  end

  assign halted = (state == HALTED);

  // write-back and fetch never share a cycle
  a_we_fetch: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.reg_we && ctrl.fetch_en));

  // a bus request starts from execute and always hands over to bus
  a_bus_start: assert property (@(posedge clk) disable iff (reset)
    ctrl.bus_start |-> (state == EXECUTE) ##1 (state == BUS));

endmodule

//--- cpu_io_master.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_io_master
(
  input  logic                   clk,
  input  logic                   reset,
  input  cpu_isa_pkg::ctrl_t     ctrl,
  input  logic [`CPU_ADR_W-1:0]  adr,
  input  logic [`CPU_DATA_W-1:0] wdata,
  input  cpu_bus_pkg::wb_rsp_t   wb_rsp,
  output cpu_bus_pkg::wb_req_t   wb_req,
  output logic [`CPU_DATA_W-1:0] rdata,
  output logic                   bus_done
);

  logic                   cyc_q;
  logic                   stb_q;
  logic                   we_q;
  logic                   done_q;
  logic [`CPU_ADR_W-1:0]  adr_q;
  logic [`CPU_DATA_W-1:0] dat_q;
  logic [`CPU_DATA_W-1:0] rdata_q;
  logic                   ack_seen;

  // the slave ends the cycle with ack while we are active
  assign ack_seen = cyc_q && wb_rsp.ack;

  // cycle control
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      cyc_q  <= 1'b0;
      stb_q  <= 1'b0;
      we_q   <= 1'b0;
      done_q <= 1'b0;
    end
    else
    begin
      // done is a single cycle pulse after the ack edge
      done_q <= ack_seen;
      if (ctrl.bus_start)
      begin
        cyc_q <= 1'b1;
        stb_q <= 1'b1;
        we_q  <= ctrl.bus_we;
      end
      else if (ack_seen)
      begin
        cyc_q <= 1'b0;
        stb_q <= 1'b0;
        we_q  <= 1'b0;
      end
    end
  end

  // request payload, held from bus_start to ack
  always_ff @(posedge clk)
  begin
    if (ctrl.bus_start)
    begin
      adr_q <= adr;
      dat_q <= wdata;
    end
    // read data captured on the ack edge
    if (ack_seen && !we_q)
      rdata_q <= wb_rsp.dat;
  end

  // single transfer per cycle, strobe raised and dropped with the cycle
  assign wb_req = '{cyc: cyc_q, stb: stb_q, we: we_q, adr: adr_q, dat: dat_q};

  assign rdata    = rdata_q;
  assign bus_done = done_q;

  a_stb_cyc: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb |-> wb_req.cyc);

  // classic handshake, nothing moves until the slave acks
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req));

endmodule

//--- cpu_alu.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_alu
(
  input  logic                   clk,
  input  logic                   reset,
  input  cpu_isa_pkg::instr_t    instr,
  input  cpu_isa_pkg::ctrl_t     ctrl,
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  output logic [`CPU_DATA_W-1:0] y,
  output logic                   zero
);

  import cpu_isa_pkg::*;

  logic [7:0]             imm;
  logic [`CPU_DATA_W-1:0] imm_ext;

  // ldi immediate is the low byte of the instruction
  assign imm     = {instr.ra, instr.rb};
  assign imm_ext = {{(`CPU_DATA_W-8){imm[7]}}, imm};

  // result, arithmetic wraps at the data width
  always_comb
  begin
    unique case (ctrl.alu_op)
      ALU_ADD:
        y = a + b;
      ALU_SUB:
        y = a - b;
      ALU_AND:
        y = a & b;
      ALU_OR:
        y = a | b;
      ALU_XOR:
        y = a ^ b;
      ALU_IMM:
        y = imm_ext;
      default:
        y = '0;
    endcase
  end

  // zero flag flip-flop with load enable
  // only alu ops load it, ldi leaves it alone
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      zero <= 1'b0;
    else if (ctrl.flag_load)
      zero <= (y == '0);
  end

endmodule

//--- cpu_regfile.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_regfile
(
  input  logic                   clk,
  input  logic                   reset,
  input  cpu_isa_pkg::instr_t    instr,
  input  cpu_isa_pkg::ctrl_t     ctrl,
  input  logic [`CPU_DATA_W-1:0] alu_y,
  input  logic [`CPU_DATA_W-1:0] rdata,
  output logic [`CPU_DATA_W-1:0] rd1,
  output logic [`CPU_DATA_W-1:0] rd2
);

  import cpu_isa_pkg::*;

  localparam int NREGS = 1 << `CPU_REG_W;

  logic [`CPU_DATA_W-1:0] regs [0:NREGS-1];
  logic [`CPU_DATA_W-1:0] wdata;

  // write-back source, load data or alu result
  assign wdata = (ctrl.wb_src == SRC_BUS) ? rdata : alu_y;

  // single synchronous write port, r0 is never written
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < NREGS; i++)
        regs[i] <= '0;
    end
    else if (ctrl.reg_we && instr.rd != '0)
      regs[instr.rd] <= wdata;
  end

  // two combinational read ports
  // rd1 is operand a and store data, rd2 is operand b and bus address
  assign rd1 = (instr.ra != '0) ? regs[instr.ra] : '0;
  assign rd2 = (instr.rb != '0) ? regs[instr.rb] : '0;

  // a write must come from a fully known instruction
  a_we_known: assert property (@(posedge clk) disable iff (reset)
    ctrl.reg_we |-> !$isunknown(instr));

endmodule

//--- cpu_fetch.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_fetch
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetch_en,
  input  logic                   branch_take,
  input  logic [`CPU_DATA_W-1:0] instr_word,
  output logic [`CPU_PC_W-1:0]   iaddr,
  output cpu_isa_pkg::instr_t    instr
);

  import cpu_isa_pkg::*;

  logic [`CPU_PC_W-1:0] pc;
  logic [`CPU_PC_W-1:0] pc_inc;
  logic [`CPU_PC_W-1:0] pc_target;
  logic [`CPU_PC_W-1:0] pc_nxt;
  instr_t               ir;

  // pc adder, wraps at the top of the program space
  assign pc_inc = pc + 1'b1;

  // jump target sits in the low bits of the held instruction
  assign pc_target = ir[`CPU_PC_W-1:0];

  // a taken branch only happens in execute, fetch_en only in fetch
  // so the target simply wins over the increment
  always_comb
  begin
    pc_nxt = pc;
    if (fetch_en)
      pc_nxt = pc_inc;
    if (branch_take)
      pc_nxt = pc_target;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc <= '0;
      // start from a nop so the decoder sees a harmless word
      ir <= '{opcode: NOP, rd: '0, ra: '0, rb: '0};
    end
    else
    begin
      pc <= pc_nxt;
      // instruction port answers in the same cycle
      if (fetch_en)
        ir <= instr_t'(instr_word);
    end
  end

  assign iaddr = pc;
  assign instr = ir;

endmodule

//--- cpu_bus_pkg.sv
`include "cpu_config.svh"

package cpu_bus_pkg;

  // wishbone classic master to slave signals
  // stb always follows cyc in this design, no byte selects
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`CPU_ADR_W-1:0] adr;
    logic [`CPU_DATA_W-1:0] dat;
  } wb_req_t;

  // slave to master, no err or rty
  typedef struct packed {
    logic                   ack;
    logic [`CPU_DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

//--- cpu_isa_pkg.sv
`include "cpu_config.svh"

package cpu_isa_pkg;

  // instruction opcodes, codes 12 to 14 are unused and decode as nop
  typedef enum logic [3:0] {
    NOP  = 4'h0,
    ADD  = 4'h1,
    SUB  = 4'h2,
    AND  = 4'h3,
    OR   = 4'h4,
    XOR  = 4'h5,
    LDI  = 4'h6,
    JMP  = 4'h7,
    JZ   = 4'h8,
    JNZ  = 4'h9,
    LD   = 4'ha,
    ST   = 4'hb,
    HALT = 4'hf
  } opcode_e;

  // alu operation select
  // ALU_IMM passes the sign-extended 8-bit immediate
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_IMM = 3'd5
  } alu_op_e;

  // write-back source for the register file
  typedef enum logic {
    SRC_ALU = 1'b0,
    SRC_BUS = 1'b1
  } wb_src_e;

  // instruction word layout
  // ldi uses {ra, rb} as immediate, jumps use the low pc bits as target
  typedef struct packed {
    opcode_e               opcode;
    logic [`CPU_REG_W-1:0] rd;
    logic [`CPU_REG_W-1:0] ra;
    logic [`CPU_REG_W-1:0] rb;
  } instr_t;

  // control word from the decoder to the datapath
  typedef struct packed {
    logic    reg_we;
    wb_src_e wb_src;
    alu_op_e alu_op;
    logic    flag_load;
    logic    fetch_en;
    logic    branch_take;
    logic    bus_start;
    logic    bus_we;
  } ctrl_t;

endpackage

//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path and register width
`define CPU_DATA_W 16

// program counter width, also the instruction port address width
`define CPU_PC_W 10

// register index width, sixteen registers
`define CPU_REG_W 4

// wishbone address width
`define CPU_ADR_W 16

`endif
